// ==== hdl/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	// instruction field positions
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int SHAMT_LSB  = 6;

	// opcode field
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_BNE     = 6'h05;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_ANDI    = 6'h0c;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_LUI     = 6'h0f;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	// funct field of SPECIAL
	localparam funct_t FN_SLL   = 6'h00;
	localparam funct_t FN_MFHI  = 6'h10;
	localparam funct_t FN_MFLO  = 6'h12;
	localparam funct_t FN_MULTU = 6'h19;
	localparam funct_t FN_ADDU  = 6'h21;
	localparam funct_t FN_SUBU  = 6'h23;
	localparam funct_t FN_AND   = 6'h24;
	localparam funct_t FN_OR    = 6'h25;
	localparam funct_t FN_XOR   = 6'h26;
	localparam funct_t FN_SLT   = 6'h2a;

endpackage

// ==== hdl/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_SLT = 4'd5;
	localparam alu_op_t ALU_SLL = 4'd6;
	localparam alu_op_t ALU_LUI = 4'd7;
	localparam alu_op_t ALU_HI  = 4'd8;
	localparam alu_op_t ALU_LO  = 4'd9;

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_DONE
	} mul_state_t;

	// one partial product per cycle
	localparam int MUL_CYCLES = 32;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile
	import cpu_isa_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      we,
	input  reg_addr_t waddr,
	input  uint32_t   wdata,
	input  reg_addr_t raddr_a,
	input  reg_addr_t raddr_b,
	output uint32_t   rdata_a,
	output uint32_t   rdata_b
);

	uint32_t regs [32];
	logic    wr_live;

	// $0 never written
	assign wr_live = we && (waddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[waddr] <= wdata;
		end
	end

	// same-cycle write bypass
	assign rdata_a = (wr_live && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (wr_live && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// ==== hdl/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  logic    branch_taken,
	input  uint32_t branch_target,
	output logic    ibus_read,
	output uint32_t ibus_addr,
	input  uint32_t ibus_rddata,
	input  logic    ibus_stall,
	output logic    instr_valid,
	output uint32_t instr,
	output uint32_t instr_pc
);

	logic    active;
	uint32_t pc;
	logic    hold_valid;
	uint32_t hold_instr;
	uint32_t hold_pc;
	logic    redir_pending;
	logic    drop_next;
	uint32_t redir_target;
	logic    fire;
	logic    squash;
	logic    keep_word;

	assign ibus_read = active & ~hold_valid;
	assign ibus_addr = pc;
	assign fire      = ibus_read & ~ibus_stall;
	// delay slot sits in ID, so younger words are dead
	assign squash    = branch_taken & instr_valid;
	assign keep_word = fire & ~drop_next & ~squash;

	always_ff @(posedge clk) begin
		if (rst) begin
			active        <= 1'b0;
			pc            <= RESET_PC;
			redir_pending <= 1'b0;
			drop_next     <= 1'b0;
		end else begin
			active <= 1'b1;
			if (branch_taken && ibus_read && ibus_stall) begin
				// stalled request keeps its address until it completes
				redir_pending <= 1'b1;
				redir_target  <= branch_target;
				drop_next     <= instr_valid;
			end else if (branch_taken) begin
				pc <= branch_target;
			end else if (fire) begin
				pc            <= redir_pending ? redir_target : pc + 32'd4;
				redir_pending <= 1'b0;
				drop_next     <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			instr_valid <= 1'b0;
			hold_valid  <= 1'b0;
		end else if (!stall) begin
			if (hold_valid && !squash) begin
				instr_valid <= 1'b1;
				instr       <= hold_instr;
				instr_pc    <= hold_pc;
			end else if (keep_word) begin
				instr_valid <= 1'b1;
				instr       <= ibus_rddata;
				instr_pc    <= pc;
			end else begin
				instr_valid <= 1'b0;
			end
			hold_valid <= 1'b0;
		end else if (keep_word) begin
			// ID busy, park the word
			hold_valid <= 1'b1;
			hold_instr <= ibus_rddata;
			hold_pc    <= pc;
		end
	end

endmodule

// ==== hdl/decode_and_issue.sv ====
`timescale 1ns/1ps

module decode_and_issue
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic      instr_valid,
	input  uint32_t   instr,
	input  uint32_t   instr_pc,
	output reg_addr_t raddr_a,
	output reg_addr_t raddr_b,
	input  uint32_t   rdata_a,
	input  uint32_t   rdata_b,
	input  reg_addr_t ex_rd,
	input  logic      ex_we,
	input  uint32_t   ex_value,
	input  logic      ex_is_load,
	input  reg_addr_t mm_rd,
	input  logic      mm_we,
	input  uint32_t   mm_value,
	input  reg_addr_t wb_rd,
	input  logic      wb_we,
	input  uint32_t   wb_value,
	output alu_op_t   dec_alu_op,
	output uint32_t   dec_op_a,
	output uint32_t   dec_op_b,
	output uint32_t   dec_store_data,
	output reg_addr_t dec_rd,
	output logic      dec_we,
	output logic      dec_load,
	output logic      dec_store,
	output logic      dec_branch_eq,
	output logic      dec_branch_ne,
	output logic      dec_mult,
	output logic      dec_hilo_read,
	output uint32_t   dec_imm,
	output uint32_t   dec_pc,
	output logic      load_use_stall
);

	opcode_t    opcode;
	funct_t     funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd_field;
	logic [4:0] shamt;
	logic [15:0] imm16;
	logic       use_imm;
	logic       shift_op;
	logic       uses_rs;
	logic       uses_rt;
	uint32_t    rs_val;
	uint32_t    rt_val;

	assign opcode   = instr[31:OPCODE_LSB];
	assign rs       = instr[RS_LSB +: 5];
	assign rt       = instr[RT_LSB +: 5];
	assign rd_field = instr[RD_LSB +: 5];
	assign shamt    = instr[SHAMT_LSB +: 5];
	assign funct    = instr[5:0];
	assign imm16    = instr[15:0];

	assign raddr_a = rs;
	assign raddr_b = rt;
	assign dec_pc  = instr_pc;

	// nearest producer wins
	function automatic uint32_t fwd(input reg_addr_t r, input uint32_t rf);
		if (r == '0)
			return '0;
		if (ex_we && ex_rd == r)
			return ex_value;
		if (mm_we && mm_rd == r)
			return mm_value;
		if (wb_we && wb_rd == r)
			return wb_value;
		return rf;
	endfunction

	always_comb begin
		dec_alu_op    = ALU_ADD;
		dec_rd        = rt;
		dec_we        = 1'b0;
		dec_load      = 1'b0;
		dec_store     = 1'b0;
		dec_branch_eq = 1'b0;
		dec_branch_ne = 1'b0;
		dec_mult      = 1'b0;
		dec_hilo_read = 1'b0;
		dec_imm       = {{16{imm16[15]}}, imm16};
		use_imm       = 1'b0;
		shift_op      = 1'b0;
		uses_rs       = 1'b1;
		uses_rt       = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				dec_rd  = rd_field;
				dec_we  = 1'b1;
				uses_rt = 1'b1;
				case (funct)
					FN_ADDU: dec_alu_op = ALU_ADD;
					FN_SUBU: dec_alu_op = ALU_SUB;
					FN_AND:  dec_alu_op = ALU_AND;
					FN_OR:   dec_alu_op = ALU_OR;
					FN_XOR:  dec_alu_op = ALU_XOR;
					FN_SLT:  dec_alu_op = ALU_SLT;
					FN_SLL: begin
						dec_alu_op = ALU_SLL;
						shift_op   = 1'b1;
						uses_rs    = 1'b0;
					end
					FN_MULTU: begin
						dec_we   = 1'b0;
						dec_mult = 1'b1;
					end
					FN_MFHI, FN_MFLO: begin
						dec_alu_op    = (funct == FN_MFHI) ? ALU_HI : ALU_LO;
						dec_hilo_read = 1'b1;
						uses_rs       = 1'b0;
						uses_rt       = 1'b0;
					end
					default: dec_we = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				dec_we  = 1'b1;
				use_imm = 1'b1;
			end
			OP_ANDI, OP_ORI: begin
				dec_alu_op = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
				dec_imm    = {16'h0000, imm16};
				dec_we     = 1'b1;
				use_imm    = 1'b1;
			end
			OP_LUI: begin
				dec_alu_op = ALU_LUI;
				dec_imm    = {imm16, 16'h0000};
				dec_we     = 1'b1;
				use_imm    = 1'b1;
				uses_rs    = 1'b0;
			end
			OP_LW: begin
				dec_we   = 1'b1;
				dec_load = 1'b1;
			end
			OP_SW: begin
				dec_store = 1'b1;
				uses_rt   = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				dec_branch_eq = (opcode == OP_BEQ);
				dec_branch_ne = (opcode == OP_BNE);
				uses_rt       = 1'b1;
			end
			default: uses_rs = 1'b0;
		endcase
		if (!instr_valid) begin
			dec_we        = 1'b0;
			dec_load      = 1'b0;
			dec_store     = 1'b0;
			dec_branch_eq = 1'b0;
			dec_branch_ne = 1'b0;
			dec_mult      = 1'b0;
			dec_hilo_read = 1'b0;
			uses_rs       = 1'b0;
			uses_rt       = 1'b0;
		end
	end

	always_comb begin
		rs_val = fwd(rs, rdata_a);
		rt_val = fwd(rt, rdata_b);
	end

	// sll shifts rt by shamt
	assign dec_op_a       = shift_op ? rt_val : rs_val;
	assign dec_op_b       = shift_op ? {27'd0, shamt} : (use_imm ? dec_imm : rt_val);
	assign dec_store_data = rt_val;

	assign load_use_stall = ex_is_load && (ex_rd != '0) &&
		((uses_rs && rs == ex_rd) || (uses_rt && rt == ex_rd));

endmodule

// ==== hdl/instr_exec.sv ====
`timescale 1ns/1ps

module instr_exec
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  alu_op_t alu_op,
	input  uint32_t op_a,
	input  uint32_t op_b,
	input  uint32_t imm,
	input  uint32_t pc,
	input  logic    is_load,
	input  logic    is_store,
	input  logic    branch_eq,
	input  logic    branch_ne,
	input  uint32_t hi,
	input  uint32_t lo,
	output uint32_t result,
	output uint32_t mem_addr,
	output logic    branch_taken,
	output uint32_t branch_target
);

	logic operands_equal;
	logic less_signed;

	assign operands_equal = (op_a == op_b);
	assign less_signed    = $signed(op_a) < $signed(op_b);

	always_comb begin
		case (alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_SLT: result = {31'd0, less_signed};
			ALU_SLL: result = op_a << op_b[4:0];
			// upper immediate already formed in decode
			ALU_LUI: result = op_b;
			ALU_HI:  result = hi;
			ALU_LO:  result = lo;
			default: result = '0;
		endcase
	end

	// bus address stays quiet for non-memory ops
	assign mem_addr = (is_load || is_store) ? op_a + imm : '0;

	assign branch_taken  = (branch_eq && operands_equal) || (branch_ne && !operands_equal);
	// relative to the delay slot
	assign branch_target = pc + 32'd4 + {imm[29:0], 2'b00};

endmodule

// ==== hdl/multi_cycle_exec.sv ====
`timescale 1ns/1ps

module multi_cycle_exec
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  logic    start,
	input  uint32_t op_a,
	input  uint32_t op_b,
	output logic    busy,
	output uint32_t hi,
	output uint32_t lo
);

	localparam int CNT_W = $clog2(MUL_CYCLES);

	mul_state_t       state;
	logic [CNT_W-1:0] count;
	logic [63:0]      prod;
	uint32_t          mcand;
	logic [32:0]      step_sum;
	logic             accept;

	assign busy     = (state != MUL_IDLE);
	assign accept   = (state == MUL_IDLE) && start && !stall;
	// add multiplicand into the upper half when the low bit is set
	assign step_sum = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MUL_IDLE;
			count <= '0;
			hi    <= '0;
			lo    <= '0;
		end else begin
			case (state)
				MUL_IDLE: begin
					if (accept) begin
						state <= MUL_RUN;
						count <= '0;
					end
				end
				MUL_RUN: begin
					count <= count + 1'b1;
					if (count == CNT_W'(MUL_CYCLES - 1))
						state <= MUL_DONE;
				end
				MUL_DONE: begin
					hi    <= prod[63:32];
					lo    <= prod[31:0];
					state <= MUL_IDLE;
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			prod  <= {32'd0, op_b};
			mcand <= op_a;
		end else if (state == MUL_RUN) begin
			prod <= {step_sum, prod[31:1]};
		end
	end

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	output logic    ibus_read,
	output uint32_t ibus_addr,
	input  uint32_t ibus_rddata,
	input  logic    ibus_stall,
	output logic    dbus_read,
	output logic    dbus_write,
	output uint32_t dbus_addr,
	output uint32_t dbus_wdata,
	input  uint32_t dbus_rddata,
	input  logic    dbus_stall
);

	logic stall_if, stall_id, stall_ex, stall_mm;
	logic flush_ex, flush_mm;
	logic load_use_stall, mul_stall, branch_go;

	logic    instr_valid;
	uint32_t instr, instr_pc;

	reg_addr_t raddr_a, raddr_b;
	uint32_t   rdata_a, rdata_b;

	alu_op_t   dec_alu_op;
	uint32_t   dec_op_a, dec_op_b, dec_store_data, dec_imm, dec_pc;
	reg_addr_t dec_rd;
	logic      dec_we, dec_load, dec_store, dec_branch_eq, dec_branch_ne;
	logic      dec_mult, dec_hilo_read;

	// ID/EX
	alu_op_t   ex_alu_op;
	uint32_t   ex_op_a, ex_op_b, ex_store_data, ex_imm, ex_pc;
	reg_addr_t ex_rd;
	logic      ex_we, ex_load, ex_store, ex_beq, ex_bne, ex_mult, ex_hilo_read;

	uint32_t ex_result, ex_mem_addr, ex_branch_target;
	logic    ex_branch_taken;
	logic    mul_busy;
	uint32_t hi, lo;

	// EX/MEM
	uint32_t   mm_result, mm_addr, mm_store_data, mm_value;
	reg_addr_t mm_rd;
	logic      mm_we, mm_load, mm_store;

	// MEM/WB
	uint32_t   wb_wdata;
	reg_addr_t wb_rd;
	logic      wb_we;

	assign stall_mm  = dbus_stall & (mm_load | mm_store);
	assign mul_stall = mul_busy & (ex_mult | ex_hilo_read);
	assign stall_ex  = stall_mm | mul_stall;
	assign stall_id  = stall_ex | load_use_stall;
	// ibus_stall is absorbed inside fetch
	assign stall_if  = stall_id;
	assign flush_ex  = stall_id & ~stall_ex;
	assign flush_mm  = stall_ex & ~stall_mm;
	assign branch_go = ex_branch_taken & ~stall_ex;

	instr_fetch instr_fetch_inst (
		.clk, .rst,
		.stall         ( stall_if         ),
		.branch_taken  ( branch_go        ),
		.branch_target ( ex_branch_target ),
		.ibus_read, .ibus_addr, .ibus_rddata, .ibus_stall,
		.instr_valid, .instr, .instr_pc
	);

	regfile regfile_inst (
		.clk, .rst,
		.we    ( wb_we    ),
		.waddr ( wb_rd    ),
		.wdata ( wb_wdata ),
		.raddr_a, .raddr_b, .rdata_a, .rdata_b
	);

	decode_and_issue decode_issue_inst (
		.instr_valid, .instr, .instr_pc,
		.raddr_a, .raddr_b, .rdata_a, .rdata_b,
		.ex_rd, .ex_we,
		.ex_value   ( ex_result ),
		.ex_is_load ( ex_load   ),
		.mm_rd, .mm_we, .mm_value,
		.wb_rd, .wb_we,
		.wb_value   ( wb_wdata  ),
		.dec_alu_op, .dec_op_a, .dec_op_b, .dec_store_data, .dec_rd, .dec_we,
		.dec_load, .dec_store, .dec_branch_eq, .dec_branch_ne, .dec_mult,
		.dec_hilo_read, .dec_imm, .dec_pc, .load_use_stall
	);

	always_ff @(posedge clk) begin
		if (rst || flush_ex) begin
			ex_we <= 1'b0;
			ex_load <= 1'b0;
			ex_store <= 1'b0;
			ex_beq <= 1'b0;
			ex_bne <= 1'b0;
			ex_mult <= 1'b0;
			ex_hilo_read <= 1'b0;
		end else if (!stall_id) begin
			ex_we <= dec_we;
			ex_load <= dec_load;
			ex_store <= dec_store;
			ex_beq <= dec_branch_eq;
			ex_bne <= dec_branch_ne;
			ex_mult <= dec_mult;
			ex_hilo_read <= dec_hilo_read;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_id) begin
			ex_alu_op <= dec_alu_op;
			ex_op_a <= dec_op_a;
			ex_op_b <= dec_op_b;
			ex_store_data <= dec_store_data;
			ex_imm <= dec_imm;
			ex_pc <= dec_pc;
			ex_rd <= dec_rd;
		end
	end

	instr_exec exec_inst (
		.alu_op   ( ex_alu_op ),
		.op_a     ( ex_op_a   ),
		.op_b     ( ex_op_b   ),
		.imm      ( ex_imm    ),
		.pc       ( ex_pc     ),
		.is_load  ( ex_load   ),
		.is_store ( ex_store  ),
		.branch_eq ( ex_beq   ),
		.branch_ne ( ex_bne   ),
		.hi, .lo,
		.result        ( ex_result        ),
		.mem_addr      ( ex_mem_addr      ),
		.branch_taken  ( ex_branch_taken  ),
		.branch_target ( ex_branch_target )
	);

	// multu leaves EX as soon as the unit takes it
	multi_cycle_exec multi_cycle_exec_inst (
		.clk, .rst,
		.stall ( stall_mm             ),
		.start ( ex_mult & ~mul_stall ),
		.op_a  ( ex_op_a              ),
		.op_b  ( ex_op_b              ),
		.busy  ( mul_busy             ),
		.hi, .lo
	);

	always_ff @(posedge clk) begin
		if (rst || flush_mm) begin
			mm_we <= 1'b0;
			mm_load <= 1'b0;
			mm_store <= 1'b0;
		end else if (!stall_ex) begin
			mm_we <= ex_we;
			mm_load <= ex_load;
			mm_store <= ex_store;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_ex) begin
			mm_result <= ex_result;
			mm_addr <= ex_mem_addr;
			mm_store_data <= ex_store_data;
			mm_rd <= ex_rd;
		end
	end

	assign dbus_read  = mm_load;
	assign dbus_write = mm_store;
	assign dbus_addr  = mm_addr;
	assign dbus_wdata = mm_store_data;
	// load data only meaningful on the completing beat
	assign mm_value   = mm_load ? dbus_rddata : mm_result;

	always_ff @(posedge clk) begin
		if (rst || stall_mm) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= mm_we;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= mm_rd;
		wb_wdata <= mm_value;
	end

endmodule

// ==== dv/bus_mem_model.sv ====
`timescale 1ns/1ps

module bus_mem_model #(
	parameter logic [31:0] SEED = 32'h0000_0001
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	output logic [31:0] rddata,
	output logic        stall
);

	localparam int DEPTH = 256;

	logic [31:0] mem [DEPTH];
	logic [7:0]  idx;
	integer      seed;
	logic        stall_enable;

	initial begin
		seed         = SEED;
		stall_enable = 1'b0;
		stall        = 1'b0;
		// every word carries its own index
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = {8'ha5, ~i[7:0], 8'h3c, i[7:0]};
		end
	end

	assign idx    = addr[9:2];
	assign rddata = read ? mem[idx] : '0;

	always @(posedge clk) begin
		if (rst || !stall_enable) begin
			stall <= 1'b0;
		end else begin
			// roughly one cycle in four
			stall <= (($random(seed) & 3) == 0);
		end
		if (write && !stall) begin
			mem[idx] <= wdata;
		end
	end

endmodule

// ==== dv/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
();

	localparam logic [31:0] RAND_SEED    = 32'h70da9f0e;
	localparam uint32_t     DONE_ADDR    = 32'h0000_03fc;
	localparam int          STALL_FACTOR = 8;
	localparam int          MEM_WORDS    = 256;

	logic    clk;
	logic    rst;
	logic    ibus_read;
	logic    ibus_stall;
	uint32_t ibus_addr;
	uint32_t ibus_rddata;
	logic    dbus_read;
	logic    dbus_write;
	logic    dbus_stall;
	uint32_t dbus_addr;
	uint32_t dbus_wdata;
	uint32_t dbus_rddata;

	uint32_t prog [MEM_WORDS];
	string   prog_test [MEM_WORDS];
	uint32_t ref_mem [MEM_WORDS];
	int      prog_len;
	string   section;
	string   suffix;

	uint32_t exp_addr [$];
	uint32_t exp_data [$];
	string   exp_test [$];

	int   store_idx;
	int   run_cycles;
	int   run_limit;
	int   out_of_reset;
	int   store_errors;
	int   control_errors;
	logic running;
	logic done;
	logic rst_seen;

	cpu_core DUT (
		.clk, .rst,
		.ibus_read, .ibus_addr, .ibus_rddata, .ibus_stall,
		.dbus_read, .dbus_write, .dbus_addr, .dbus_wdata, .dbus_rddata, .dbus_stall
	);

	bus_mem_model #(.SEED(RAND_SEED)) imem (
		.clk, .rst,
		.read   ( ibus_read   ),
		.write  ( 1'b0        ),
		.addr   ( ibus_addr   ),
		.wdata  ( 32'd0       ),
		.rddata ( ibus_rddata ),
		.stall  ( ibus_stall  )
	);

	bus_mem_model #(.SEED(RAND_SEED ^ 32'h0000_ffff)) dmem (
		.clk, .rst,
		.read   ( dbus_read   ),
		.write  ( dbus_write  ),
		.addr   ( dbus_addr   ),
		.wdata  ( dbus_wdata  ),
		.rddata ( dbus_rddata ),
		.stall  ( dbus_stall  )
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic uint32_t rtype(funct_t fn, int rs, int rt, int rd, int sh);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic uint32_t itype(opcode_t op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic put_instr(input uint32_t word);
		prog[prog_len]      = word;
		prog_test[prog_len] = section;
		prog_len++;
	endtask

	task automatic put_data(input uint32_t addr, input uint32_t value);
		ref_mem[addr[9:2]]  = value;
		dmem.mem[addr[9:2]] = value;
	endtask

	task automatic build_program();
		section = "alu_forwarding";
		put_instr(itype(OP_LUI, 0, 1, 16'h1234));
		put_instr(itype(OP_ORI, 1, 1, 16'h5678));
		put_instr(itype(OP_ADDIU, 1, 2, 16'h0010));
		put_instr(rtype(FN_SUBU, 2, 1, 3, 0));
		put_instr(rtype(FN_XOR, 3, 2, 4, 0));
		put_instr(rtype(FN_AND, 4, 1, 5, 0));
		put_instr(rtype(FN_OR, 5, 3, 6, 0));
		put_instr(rtype(FN_SLL, 0, 6, 7, 4));
		put_instr(rtype(FN_SLT, 3, 2, 8, 0));
		put_instr(itype(OP_ADDIU, 0, 9, 16'hfffb));
		put_instr(rtype(FN_SLT, 9, 3, 10, 0));
		put_instr(itype(OP_ANDI, 9, 11, 16'hff0f));
		put_instr(rtype(FN_ADDU, 1, 2, 12, 0));
		put_instr(itype(OP_SW, 0, 12, 16'h0100));
		put_instr(itype(OP_SW, 0, 7, 16'h0104));
		put_instr(itype(OP_SW, 0, 8, 16'h0108));
		put_instr(itype(OP_SW, 0, 10, 16'h010c));
		put_instr(itype(OP_SW, 0, 11, 16'h0110));
		put_instr(itype(OP_SW, 0, 4, 16'h0114));
		section = "load_use";
		put_data(32'h40, 32'hcafe_0001);
		put_data(32'h44, 32'h0bad_f00d);
		put_instr(itype(OP_LW, 0, 13, 16'h0040));
		put_instr(itype(OP_ADDIU, 13, 14, 16'h0123));
		put_instr(itype(OP_SW, 0, 14, 16'h0118));
		put_instr(itype(OP_ADDIU, 0, 15, 16'h0040));
		put_instr(itype(OP_LW, 15, 16, 16'h0004));
		put_instr(itype(OP_SW, 0, 16, 16'h011c));
		section = "branches";
		put_instr(itype(OP_ADDIU, 0, 17, 16'h0001));
		put_instr(itype(OP_BEQ, 17, 17, 16'd3));
		put_instr(itype(OP_ADDIU, 0, 18, 16'h0077));
		// skipped by the taken branch
		put_instr(itype(OP_SW, 0, 17, 16'h01f0));
		put_instr(itype(OP_SW, 0, 17, 16'h01f4));
		put_instr(itype(OP_SW, 0, 18, 16'h0120));
		put_instr(itype(OP_BNE, 17, 17, 16'd2));
		put_instr(itype(OP_ADDIU, 18, 19, 16'h0001));
		put_instr(itype(OP_SW, 0, 19, 16'h0124));
		section = "multiply";
		put_instr(itype(OP_LUI, 0, 20, 16'hdead));
		put_instr(itype(OP_ORI, 20, 20, 16'hbeef));
		put_instr(rtype(FN_MULTU, 20, 1, 0, 0));
		put_instr(rtype(FN_MFHI, 0, 0, 22, 0));
		put_instr(rtype(FN_MFLO, 0, 0, 23, 0));
		put_instr(itype(OP_SW, 0, 22, 16'h0128));
		put_instr(itype(OP_SW, 0, 23, 16'h012c));
		section = "done";
		put_instr(itype(OP_SW, 0, 0, DONE_ADDR[15:0]));
		foreach (prog[i]) begin
			imem.mem[i] = prog[i];
		end
	endtask

	// sequential ISA model with one delay slot
	task automatic run_reference();
		uint32_t     regs [32];
		uint32_t     hi_r, lo_r, pc, npc, nxt_pc, ins, a, b, simm, addr, res;
		logic [63:0] prod;
		logic        wr, take;
		reg_addr_t   dst;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		hi_r = '0;
		lo_r = '0;
		pc   = RESET_PC;
		npc  = RESET_PC + 32'd4;
		for (int steps = 0; steps < 4 * MEM_WORDS; steps++) begin
			ins  = prog[pc[9:2]];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = a + simm;
			dst  = ins[20:16];
			wr   = 1'b1;
			take = 1'b0;
			res  = '0;
			case (ins[31:26])
				OP_SPECIAL: begin
					dst = ins[15:11];
					case (ins[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
						FN_SLL:  res = b << ins[10:6];
						FN_MFHI: res = hi_r;
						FN_MFLO: res = lo_r;
						FN_MULTU: begin
							prod = {32'd0, a} * {32'd0, b};
							hi_r = prod[63:32];
							lo_r = prod[31:0];
							wr   = 1'b0;
						end
						default: wr = 1'b0;
					endcase
				end
				OP_ADDIU: res = a + simm;
				OP_ANDI:  res = a & {16'h0000, ins[15:0]};
				OP_ORI:   res = a | {16'h0000, ins[15:0]};
				OP_LUI:   res = {ins[15:0], 16'h0000};
				OP_LW:    res = ref_mem[addr[9:2]];
				OP_SW: begin
					wr = 1'b0;
					if (addr == DONE_ADDR)
						break;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					exp_test.push_back(prog_test[pc[9:2]]);
					ref_mem[addr[9:2]] = b;
				end
				OP_BEQ: begin
					wr   = 1'b0;
					take = (a == b);
				end
				OP_BNE: begin
					wr   = 1'b0;
					take = (a != b);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != '0)
				regs[dst] = res;
			nxt_pc = take ? npc + {simm[29:0], 2'b00} : npc + 32'd4;
			pc     = npc;
			npc    = nxt_pc;
		end
	endtask

	task automatic run_program(input logic with_stalls);
		@(negedge clk);
		rst                = 1'b1;
		imem.stall_enable  = with_stalls;
		dmem.stall_enable  = with_stalls;
		suffix             = with_stalls ? " (back-pressure)" : "";
		store_idx          = 0;
		done               = 1'b0;
		run_cycles         = 0;
		repeat (4) @(negedge clk);
		rst     = 1'b0;
		running = 1'b1;
		while (!done) @(negedge clk);
		running = 1'b0;
		assert (store_idx == exp_addr.size()) else begin
			$display("only %0d of %0d expected stores were seen%s",
				store_idx, exp_addr.size(), suffix);
			store_errors++;
		end
	endtask

	// reset and first fetch
	always @(posedge clk) begin
		if (rst) begin
			if (rst_seen) begin
				assert (!ibus_read && !dbus_read && !dbus_write) else begin
					$display("bus request made while the core is in reset");
					control_errors++;
				end
			end
			rst_seen     = 1'b1;
			out_of_reset = 0;
		end else begin
			rst_seen = 1'b0;
			out_of_reset++;
			if (out_of_reset == 1) begin
				assert (!ibus_read && !dbus_read && !dbus_write) else begin
					$display("bus request made in the first cycle after reset");
					control_errors++;
				end
			end
			if (out_of_reset == 2) begin
				assert (ibus_read) else begin
					$display("instruction fetch did not start in the second cycle after reset");
					control_errors++;
				end
				assert (ibus_addr == RESET_PC) else begin
					$display("Error: reset first ibus_addr expected %h actual %h",
						RESET_PC, ibus_addr);
					control_errors++;
				end
			end
		end
	end

	// completed stores and run timeout
	always @(posedge clk) begin
		if (running && !done) begin
			run_cycles++;
			if (dbus_write && !dbus_stall) begin
				if (dbus_addr == DONE_ADDR) begin
					done = 1'b1;
				end else begin
					assert (store_idx < exp_addr.size()) else begin
						$display("unexpected store of %h to %h after the last expected store%s",
							dbus_wdata, dbus_addr, suffix);
						store_errors++;
					end
					if (store_idx < exp_addr.size()) begin
						assert (dbus_addr == exp_addr[store_idx]) else begin
							$display("Error: %s%s store %0d address expected %h actual %h",
								exp_test[store_idx], suffix, store_idx,
								exp_addr[store_idx], dbus_addr);
							store_errors++;
						end
						assert (dbus_wdata == exp_data[store_idx]) else begin
							$display("Error: %s%s store %0d data expected %h actual %h",
								exp_test[store_idx], suffix, store_idx,
								exp_data[store_idx], dbus_wdata);
							store_errors++;
						end
						store_idx++;
					end
				end
			end
			if (run_cycles > run_limit) begin
				$display("program did not reach its final store within %0d cycles%s",
					run_limit, suffix);
				$display("errors: %0d store, %0d control", store_errors, control_errors);
				$display("Regression failed");
				$finish;
			end
		end
	end

	initial begin
		rst            = 1'b1;
		running        = 1'b0;
		done           = 1'b0;
		rst_seen       = 1'b0;
		store_idx      = 0;
		run_cycles     = 0;
		out_of_reset   = 0;
		store_errors   = 0;
		control_errors = 0;
		prog_len       = 0;
		suffix         = "";
		foreach (prog[i]) begin
			prog[i]      = '0;
			prog_test[i] = "";
			ref_mem[i]   = '0;
		end
		@(negedge clk);
		build_program();
		run_reference();
		run_limit = (prog_len + MUL_CYCLES + 2) * STALL_FACTOR;
		run_program(1'b0);
		run_program(1'b1);
		$display("errors: %0d store, %0d control", store_errors, control_errors);
		if (store_errors == 0 && control_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/regfile.sv
hdl/instr_fetch.sv
hdl/decode_and_issue.sv
hdl/instr_exec.sv
hdl/multi_cycle_exec.sv
hdl/cpu_core.sv
dv/bus_mem_model.sv
dv/cpu_core_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - hdl/cpu_isa_pkg.sv
      - hdl/cpu_pipe_pkg.sv
      - hdl/regfile.sv
      - hdl/instr_fetch.sv
      - hdl/decode_and_issue.sv
      - hdl/instr_exec.sv
      - hdl/multi_cycle_exec.sv
      - hdl/cpu_core.sv
  - target: test
    files:
      - dv/bus_mem_model.sv
      - dv/cpu_core_tb.sv
